// ==== vlog.f ====
src/tcdm_pkg.sv
src/tcdm_fifo.sv
src/tcdm_bank.sv
src/tcdm_split.sv
src/tcdm_subsystem.sv
tests/tb_tcdm_subsystem.sv

// ==== Makefile ====
# Verilator flow for the TCDM subsystem testbench

TOP := tb_tcdm_subsystem

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing -f vlog.f --top-module tcdm_subsystem

clean:
	rm -rf obj_dir sim.log

// ==== tests/tb_tcdm_subsystem.sv ====
// **********************************************************
// testbench for the TCDM subsystem
// clock, reset, wide and external stimulus, lrdy stalls
// model memory, reference function, compare process, timeout
// **********************************************************

`timescale 1ns/100ps

module tb_tcdm_subsystem import tcdm_pkg::*; ();

  localparam int N_OPS          = 2*32 + 2*32 + (16 + 48) + 48 + 1 + 2*32;
  localparam int TIMEOUT_CYCLES = 40 * N_OPS;

  logic clk_i, rst_ni, clear_i;
  logic req_i, wen_i, gnt_o, r_valid_o, lrdy_i;
  logic [AW-1:0] add_i;
  logic [NB_CHAN*BW_CHAN-1:0] be_i;
  logic [DW_WIDE-1:0] data_i, r_data_o;
  logic [NB_CHAN-1:0] ext_req_i, ext_wen_i, ext_r_valid_o;
  logic [NB_CHAN-1:0][AW-1:0] ext_add_i;
  logic [NB_CHAN-1:0][DW_CHAN-1:0] ext_data_i, ext_r_data_o;

  logic [DW_WIDE-1:0] model_mem [BANK_WORDS];  // bank 1 word above bank 0 word
  logic [DW_WIDE-1:0] exp_q [$];               // expected wide read data in issue order
  logic [DW_WIDE-1:0] exp_word, hold_data;
  logic [NB_CHAN-1:0] ext_pend;                // ext read issued last cycle
  logic [DW_CHAN-1:0] ext_pend_data [NB_CHAN];
  logic [7:0]         mdl_idx;
  logic [31:0]        seed = 32'h9703, ext_rnd;
  logic               hold_pending, ext_on, stall_on, park_on;
  string              test_name;
  int                 cycle_cnt;

  tcdm_subsystem dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;  // 4 ns period
  end

  function automatic logic [31:0] next_rand();
    seed = seed * 32'd1664525 + 32'd1013904223;  // LCG step
    return seed;
  endfunction

  // reference wide word as the model memory holds it
  function automatic logic [DW_WIDE-1:0] expected_word(input logic [AW-1:0] add);
    return model_mem[add[10:3]];
  endfunction

  function automatic logic [DW_WIDE-1:0] merge_bytes(input logic [DW_WIDE-1:0] old_w,
      input logic [DW_WIDE-1:0] new_w, input logic [7:0] be);
    logic [DW_WIDE-1:0] res;
    res = old_w;
    for (int b = 0; b < 8; b++) if (be[b]) res[b*8 +: 8] = new_w[b*8 +: 8];
    return res;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
      input logic [63:0] actual);
    if (actual !== expected)
      fail_run($sformatf("mismatch %s expected %h actual %h", name, expected, actual));
  endtask

  // starts and ends on a falling edge and holds the request until gnt_o
  task automatic wide_access(input int idx, input logic rd, input logic [7:0] be,
      input logic [63:0] data);
    logic granted;
    req_i  = 1'b1;
    add_i  = {21'd0, 8'(idx), 3'b000};
    wen_i  = rd;
    be_i   = be;
    data_i = data;
    granted = 1'b0;
    while (!granted) begin
      #1;
      granted = gnt_o;  // settled 1 ns before the rising edge
      @(negedge clk_i);
    end
    req_i = 1'b0;
  endtask

  task automatic ext_write(input int k, input int idx, input logic [31:0] data);
    ext_req_i[k]  = 1'b1;
    ext_wen_i[k]  = 1'b0;
    ext_add_i[k]  = {21'd0, 8'(idx), 1'(k), 2'b00};
    ext_data_i[k] = data;
    @(negedge clk_i);
    ext_req_i[k] = 1'b0;
    ext_wen_i[k] = 1'b1;
  endtask

  task automatic drain();
    stall_on = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  // random lrdy low periods
  always @(negedge clk_i) begin
    if (park_on) lrdy_i = 1'b0;  // responses stay queued
    else if (stall_on) lrdy_i = ((next_rand() & 32'h3) != 32'h0);
    else lrdy_i = 1'b1;
  end

  // external reads on one bank at a time in the upper half only
  always @(negedge clk_i) begin
    if (ext_on) begin
      ext_rnd   = next_rand();
      ext_req_i = '0;
      ext_wen_i = '1;
      if (ext_rnd[0]) begin
        ext_req_i[ext_rnd[1]] = 1'b1;
        ext_add_i[ext_rnd[1]] = {21'd0, 5'b10000, ext_rnd[4:2], ext_rnd[1], 2'b00};
      end
    end
  end

  // model update and compare where outputs have settled
  always begin
    @(negedge clk_i);
    #1;
    if (rst_ni) begin
      if (r_valid_o) begin
        if (hold_pending) check_value("r_data_o hold", hold_data, r_data_o);
        if (lrdy_i) begin
          hold_pending = 1'b0;
          if (exp_q.size() == 0) begin
            fail_run("read response arrived without an outstanding wide read");
          end else begin
            exp_word = exp_q.pop_front();
            check_value(test_name, exp_word, r_data_o);
          end
        end else begin
          hold_pending = 1'b1;  // stalled so the data must not move
          hold_data    = r_data_o;
        end
      end else if (hold_pending) begin
        fail_run("r_valid_o dropped while lrdy_i was low");
      end
      if (req_i && gnt_o) begin
        if (wen_i) exp_q.push_back(expected_word(add_i));
        else model_mem[add_i[10:3]] = merge_bytes(model_mem[add_i[10:3]], data_i, be_i);
      end
      for (int k = 0; k < NB_CHAN; k++) begin
        if (ext_r_valid_o[k] !== ext_pend[k])
          fail_run("external read data did not come exactly one cycle after the request");
        else if (ext_pend[k])
          check_value("ext read", 64'(ext_pend_data[k]), 64'(ext_r_data_o[k]));
        ext_pend[k] = ext_req_i[k] & ext_wen_i[k];
        if (ext_req_i[k]) begin
          mdl_idx = ext_add_i[k][10:3];
          if (ext_wen_i[k]) ext_pend_data[k] = model_mem[mdl_idx][k*32 +: 32];
          else model_mem[mdl_idx][k*32 +: 32] = ext_data_i[k];
        end
      end
      if (clear_i) begin
        exp_q.delete();  // queued responses vanish with the clear
        hold_pending = 1'b0;
      end
    end
  end

  always @(posedge clk_i) cycle_cnt <= cycle_cnt + 1;

  initial begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    fail_run("timeout, the run did not finish within the cycle limit");
  end

  initial begin : stimulus
    int i;
    int start_cnt;
    rst_ni       = 1'b0;
    clear_i      = 1'b0;
    req_i        = 1'b0;
    wen_i        = 1'b1;
    add_i        = '0;
    be_i         = '0;
    data_i       = '0;
    lrdy_i       = 1'b1;
    ext_req_i    = '0;
    ext_wen_i    = '1;
    ext_add_i    = '0;
    ext_data_i   = '0;
    ext_pend     = '0;
    ext_on       = 1'b0;
    stall_on     = 1'b0;
    park_on      = 1'b0;
    hold_pending = 1'b0;
    cycle_cnt    = 0;
    repeat (4) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    test_name = "write_read";
    for (i = 0; i < 32; i++) wide_access(i, 1'b0, 8'hff, {next_rand(), next_rand()});
    for (i = 0; i < 32; i++) wide_access(i, 1'b1, 8'hff, '0);
    drain();

    test_name = "byte_enables";  // partial writes over known data
    for (i = 0; i < 32; i++) wide_access(i, 1'b0, 8'(next_rand()), {next_rand(), next_rand()});
    for (i = 0; i < 32; i++) wide_access(i, 1'b1, 8'hff, '0);
    drain();

    test_name = "contention";
    for (i = 0; i < 16; i++) ext_write(i / 8, 128 + (i % 8), next_rand());
    ext_on = 1'b1;
    for (i = 0; i < 48; i++) wide_access(int'(next_rand() % 32), 1'b1, 8'hff, '0);
    ext_on = 1'b0;
    @(negedge clk_i);
    ext_req_i = '0;
    drain();

    test_name = "backpressure";
    stall_on = 1'b1;
    for (i = 0; i < 48; i++) wide_access(int'(next_rand() % 32), 1'b1, 8'hff, '0);
    drain();

    test_name = "clear";
    park_on = 1'b1;
    wide_access(0, 1'b1, 8'hff, '0);
    while (!r_valid_o) @(negedge clk_i);  // one response parked in the FIFOs
    clear_i = 1'b1;
    @(negedge clk_i);
    clear_i = 1'b0;
    park_on = 1'b0;
    #1;
    check_value("clear r_valid_o", 64'd0, 64'(r_valid_o));
    @(negedge clk_i);

    test_name = "after_clear";
    start_cnt = cycle_cnt;
    wide_access(32, 1'b0, 8'hff, {next_rand(), next_rand()});
    // empty FIFOs grant in the issue cycle
    check_value("clear gnt_o latency", 64'(start_cnt + 1), 64'(cycle_cnt));
    for (i = 33; i < 64; i++) wide_access(i, 1'b0, 8'hff, {next_rand(), next_rand()});
    for (i = 32; i < 64; i++) wide_access(i, 1'b1, 8'hff, '0);
    drain();

    if (exp_q.size() == 0 && !r_valid_o) begin
      $display("TESTS PASSED");
      $finish;
    end else begin
      fail_run("responses left over at the end of the run");
    end
  end

endmodule

// ==== src/tcdm_subsystem.sv ====
// **********************************************************
// TCDM subsystem top: wide-port splitter and two banks
// each bank also has its own external priority port
// **********************************************************

`timescale 1ns/100ps

module tcdm_subsystem import tcdm_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  // wide accelerator port
  input  logic                            req_i,
  input  logic [AW-1:0]                   add_i,
  input  logic                            wen_i,
  input  logic [NB_CHAN*BW_CHAN-1:0]      be_i,
  input  logic [DW_WIDE-1:0]              data_i,
  output logic                            gnt_o,
  output logic                            r_valid_o,
  output logic [DW_WIDE-1:0]              r_data_o,
  input  logic                            lrdy_i,
  // external narrow ports, one per bank
  input  logic [NB_CHAN-1:0]              ext_req_i,
  input  logic [NB_CHAN-1:0][AW-1:0]      ext_add_i,
  input  logic [NB_CHAN-1:0]              ext_wen_i,
  input  logic [NB_CHAN-1:0][DW_CHAN-1:0] ext_data_i,
  output logic [NB_CHAN-1:0]              ext_r_valid_o,
  output logic [NB_CHAN-1:0][DW_CHAN-1:0] ext_r_data_o
);

  // splitter to bank wiring
  logic [NB_CHAN-1:0]              ch_req, ch_gnt, ch_rsp_space, ch_r_valid;
  chan_req_t [NB_CHAN-1:0]         ch_req_data;
  logic [NB_CHAN-1:0][DW_CHAN-1:0] ch_r_data;

  tcdm_split i_split (
    .clk_i, .rst_ni, .clear_i,
    .req_i, .add_i, .wen_i, .be_i, .data_i, .gnt_o,
    .r_valid_o, .r_data_o, .lrdy_i,
    .ch_req_o       ( ch_req       ),
    .ch_req_o_data  ( ch_req_data  ),
    .ch_gnt_i       ( ch_gnt       ),
    .ch_rsp_space_o ( ch_rsp_space ),
    .ch_r_valid_i   ( ch_r_valid   ),
    .ch_r_data_i    ( ch_r_data    )
  );

  for (genvar k = 0; k < NB_CHAN; k++) begin : g_bank
    tcdm_bank #(.BANK_ID(k)) i_bank (
      .clk_i, .rst_ni,
      .req_i ( ch_req[k] ), .req_data_i ( ch_req_data[k] ), .rsp_space_i ( ch_rsp_space[k] ),
      .gnt_o ( ch_gnt[k] ), .r_valid_o ( ch_r_valid[k] ), .r_data_o ( ch_r_data[k] ),
      .ext_req_i ( ext_req_i[k] ), .ext_add_i ( ext_add_i[k] ), .ext_wen_i ( ext_wen_i[k] ),
      .ext_data_i ( ext_data_i[k] ), .ext_r_valid_o ( ext_r_valid_o[k] ),
      .ext_r_data_o ( ext_r_data_o[k] )
    );
  end

endmodule

// ==== src/tcdm_split.sv ====
// **********************************************************
// wide-to-channel splitter for the shared TCDM
// grant mask over the channel request FIFOs
// response join over the channel response FIFOs
// **********************************************************

`timescale 1ns/100ps

module tcdm_split import tcdm_pkg::*; (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            clear_i,
  // wide port, req/gnt
  input  logic                            req_i,
  input  logic [AW-1:0]                   add_i,
  input  logic                            wen_i,  // 1 = read
  input  logic [NB_CHAN*BW_CHAN-1:0]      be_i,
  input  logic [DW_WIDE-1:0]              data_i,
  output logic                            gnt_o,
  // wide port, r_valid/lrdy
  output logic                            r_valid_o,
  output logic [DW_WIDE-1:0]              r_data_o,
  input  logic                            lrdy_i,
  // channel side, one per bank
  output logic [NB_CHAN-1:0]              ch_req_o,
  output chan_req_t [NB_CHAN-1:0]         ch_req_o_data,
  input  logic [NB_CHAN-1:0]              ch_gnt_i,
  output logic [NB_CHAN-1:0]              ch_rsp_space_o,
  input  logic [NB_CHAN-1:0]              ch_r_valid_i,
  input  logic [NB_CHAN-1:0][DW_CHAN-1:0] ch_r_data_i
);

  logic [NB_CHAN-1:0]      mask_q, mask_d;  // halves already queued
  logic [NB_CHAN-1:0]      push_valid, push_ready, accept;
  logic [NB_CHAN-1:0]      rsp_push_ready, rsp_valid, rsp_pop;
  chan_req_t [NB_CHAN-1:0] ch_req;
  chan_rsp_t [NB_CHAN-1:0] rsp_in, rsp_head;

  for (genvar k = 0; k < NB_CHAN; k++) begin : g_chan
    // slice k of the wide word, next 32-bit word in memory
    assign ch_req[k].add  = add_i + AW'(k * BW_CHAN);
    assign ch_req[k].wen  = wen_i;
    assign ch_req[k].be   = be_i[k*BW_CHAN +: BW_CHAN];
    assign ch_req[k].data = data_i[k*DW_CHAN +: DW_CHAN];

    assign push_valid[k] = req_i & ~mask_q[k];  // masked half never pushes twice
    assign accept[k]     = push_valid[k] & push_ready[k];

    tcdm_fifo #(
      .payload_t ( chan_req_t ),
      .DEPTH     ( FIFO_DEPTH )
    ) i_req_fifo (
      .clk_i        ( clk_i            ),
      .rst_ni       ( rst_ni           ),
      .clear_i      ( clear_i          ),
      .push_valid_i ( push_valid[k]    ),
      .push_data_i  ( ch_req[k]        ),
      .push_ready_o ( push_ready[k]    ),
      .pop_valid_o  ( ch_req_o[k]      ),
      .pop_data_o   ( ch_req_o_data[k] ),
      .pop_ready_i  ( ch_gnt_i[k]      )  // bank grant pops the head
    );

    // read data from the bank, queued until the other half shows up
    assign rsp_in[k].r_data = ch_r_data_i[k];

    // a response landing now still owns its slot
    // so the bank only grants with a free slot beyond it
    assign ch_rsp_space_o[k] = rsp_push_ready[k] & ~ch_r_valid_i[k];

    tcdm_fifo #(
      .payload_t ( chan_rsp_t ),
      .DEPTH     ( FIFO_DEPTH )
    ) i_rsp_fifo (
      .clk_i        ( clk_i             ),
      .rst_ni       ( rst_ni            ),
      .clear_i      ( clear_i           ),
      .push_valid_i ( ch_r_valid_i[k]   ),
      .push_data_i  ( rsp_in[k]         ),
      .push_ready_o ( rsp_push_ready[k] ),
      .pop_valid_o  ( rsp_valid[k]      ),
      .pop_data_o   ( rsp_head[k]       ),
      .pop_ready_i  ( rsp_pop[k]        )
    );

    assign rsp_pop[k] = r_valid_o & lrdy_i;  // both halves leave together
    assign r_data_o[k*DW_CHAN +: DW_CHAN] = rsp_head[k].r_data;
  end

  // wide grant once every half is queued or going in now
  assign gnt_o  = req_i & (&(mask_q | accept));
  assign mask_d = gnt_o ? '0 : (mask_q | accept);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mask_q <= '0;
    end else if (clear_i) begin
      mask_q <= '0;
    end else begin
      mask_q <= mask_d;
    end
  end

  // join, only with both heads present
  assign r_valid_o = &rsp_valid;

  // channel k lands on bank k only for 8-byte aligned wide addresses
  a_wide_aligned: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (add_i[2:0] == 3'b000));

  // the mask assumes the same wide request until gnt_o
  a_req_held: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (req_i && !gnt_o) |=> (req_i && $stable(add_i) && $stable(wen_i)));

endmodule

// ==== src/tcdm_bank.sv ====
// **********************************************************
// single-port 32-bit TCDM bank
// split channel vs. external port, external wins
// byte-enabled writes, registered read data
// **********************************************************

`timescale 1ns/100ps

module tcdm_bank import tcdm_pkg::*; #(
  parameter int unsigned BANK_ID = 0  // channel served by this bank
) (
  input  logic               clk_i,
  input  logic               rst_ni,
  // split channel
  input  logic               req_i,
  input  chan_req_t          req_data_i,
  input  logic               rsp_space_i,
  output logic               gnt_o,
  output logic               r_valid_o,
  output logic [DW_CHAN-1:0] r_data_o,
  // external narrow port
  input  logic               ext_req_i,
  input  logic [AW-1:0]      ext_add_i,
  input  logic               ext_wen_i,  // 1 = read
  input  logic [DW_CHAN-1:0] ext_data_i,
  output logic               ext_r_valid_o,
  output logic [DW_CHAN-1:0] ext_r_data_o
);

  logic [DW_CHAN-1:0] mem_q [BANK_WORDS];
  logic [DW_CHAN-1:0] rdata_q;
  logic [BANK_AW-1:0] ch_idx, ext_idx, idx;
  logic               rd, wr_ch, wr_ext;

  // channel waits for an idle external port and a reserved rsp slot
  assign gnt_o = req_i & ~ext_req_i & rsp_space_i;

  // word index from bits 10:3, bit 2 picks the bank
  assign ch_idx  = req_data_i.add[BANK_AW+2:3];
  assign ext_idx = ext_add_i[BANK_AW+2:3];
  assign idx     = ext_req_i ? ext_idx : ch_idx;  // one port, one address

  assign rd     = (ext_req_i & ext_wen_i) | (gnt_o & req_data_i.wen);
  assign wr_ext = ext_req_i & ~ext_wen_i;  // full word
  assign wr_ch  = gnt_o & ~req_data_i.wen;

  always_ff @(posedge clk_i) begin
    if (wr_ext) begin
      mem_q[idx] <= ext_data_i;
    end else if (wr_ch) begin
      for (int b = 0; b < BW_CHAN; b++) begin
        if (req_data_i.be[b]) mem_q[idx][b*8 +: 8] <= req_data_i.data[b*8 +: 8];
      end
    end
    if (rd) rdata_q <= mem_q[idx];
  end

  // read valids, one cycle after the access
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_valid_o     <= 1'b0;
      ext_r_valid_o <= 1'b0;
    end else begin
      r_valid_o     <= gnt_o & req_data_i.wen;
      ext_r_valid_o <= ext_req_i & ext_wen_i;
    end
  end

  assign r_data_o     = rdata_q;  // shared read register
  assign ext_r_data_o = rdata_q;

  // splitter address offset must agree with bank placement
  a_bank_sel: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> (req_data_i.add[2] == 1'(BANK_ID)));

endmodule

// ==== src/tcdm_fifo.sv ====
// **********************************************************
// synchronous valid/ready FIFO with the payload given as a type
// circular buffer with read/write pointers and a count
// **********************************************************

`timescale 1ns/100ps

module tcdm_fifo #(
  parameter type         payload_t = logic [31:0],
  parameter int unsigned DEPTH     = 4
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     clear_i,
  // write side
  input  logic     push_valid_i,
  input  payload_t push_data_i,
  output logic     push_ready_o,
  // read side
  output logic     pop_valid_o,
  output payload_t pop_data_o,
  input  logic     pop_ready_i
);

  localparam int unsigned PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CW = $clog2(DEPTH + 1);

  payload_t      mem_q [DEPTH];
  logic [PW-1:0] wptr_q, rptr_q;
  logic [CW-1:0] cnt_q;  // occupancy
  logic          push, pop;

  assign push_ready_o = (cnt_q != CW'(DEPTH));
  assign pop_valid_o  = (cnt_q != '0);
  assign pop_data_o   = mem_q[rptr_q];  // head stays until popped

  assign push = push_valid_i & push_ready_o;
  assign pop  = pop_valid_o & pop_ready_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else if (clear_i) begin
      wptr_q <= '0;
      rptr_q <= '0;
      cnt_q  <= '0;
    end else begin
      if (push) wptr_q <= (wptr_q == PW'(DEPTH - 1)) ? '0 : wptr_q + PW'(1);
      if (pop)  rptr_q <= (rptr_q == PW'(DEPTH - 1)) ? '0 : rptr_q + PW'(1);
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CW'(1);
        2'b01:   cnt_q <= cnt_q - CW'(1);
        default: cnt_q <= cnt_q;  // idle or push+pop
      endcase
    end
  end

  // storage readable one cycle after the write at the earliest
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wptr_q] <= push_data_i;
  end

  // a push held off while full has to stay up until it is taken
  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni || clear_i)
    (push_valid_i && !push_ready_o) |=> push_valid_i);

  // the consumer never pops an empty queue
  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !pop_valid_o |-> !pop_ready_i);

endmodule

// ==== src/tcdm_pkg.sv ====
// **********************************************************
// widths, depths and channel count of the TCDM splitter
// channel request and response payload structs
// **********************************************************

package tcdm_pkg;

  // wide accelerator port
  localparam int unsigned AW      = 32;  // byte address
  localparam int unsigned DW_WIDE = 64;

  // split channels, one bank each
  localparam int unsigned NB_CHAN = 2;
  localparam int unsigned DW_CHAN = 32;
  localparam int unsigned BW_CHAN = 4;   // byte enables per channel

  // bank geometry
  localparam int unsigned BANK_WORDS = 256;
  localparam int unsigned BANK_AW    = $clog2(BANK_WORDS);  // word index bits

  localparam int unsigned FIFO_DEPTH = 4;  // req and rsp queues alike

  // one half of a wide request
  typedef struct packed {
    logic [AW-1:0]      add;
    logic               wen;   // 1 = read
    logic [BW_CHAN-1:0] be;
    logic [DW_CHAN-1:0] data;
  } chan_req_t;

  typedef struct packed {
    logic [DW_CHAN-1:0] r_data;
  } chan_rsp_t;

endpackage
